//--- rtl/duel_pkg.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// duel game shared definitions
// grid size, field types, start values, game state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package duel_pkg;

	localparam int GRID = 8; // side of the square board

	// row 0 is the top of the board, col 0 the left edge
	typedef logic [2:0] row_t;
	typedef logic [2:0] col_t;

	typedef logic [3:0] life_t;
	typedef logic [3:0] ammo_t;

	localparam life_t LIFE_FULL = 4'd15;
	localparam ammo_t AMMO_FULL = 4'd9;

	localparam row_t A_START_ROW = 3'd7; // A starts at the bottom
	localparam row_t B_START_ROW = 3'd0;
	localparam col_t START_COL   = 3'd4;

	typedef enum logic [1:0]
	{
		ST_PLAY,
		ST_A_WINS,
		ST_B_WINS,
		ST_DRAW
	} game_state_t;

endpackage

`default_nettype wire

//--- rtl/volley_if.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// volley link, one player's two bullets
// from the shooter to the judge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface volley_if
	import duel_pkg::*;
();

	logic up_live;
	row_t up_row;
	logic down_live;
	row_t down_row;
	col_t col;       // column the volley was fired in
	logic kill_up;   // one cycle, retire the up bullet
	logic kill_down;

	modport source
	(
		output up_live, up_row, down_live, down_row, col,
		input  kill_up, kill_down
	);

	modport judge
	(
		input  up_live, up_row, down_live, down_row, col,
		output kill_up, kill_down
	);

endinterface

`default_nettype wire

//--- rtl/tick_gen.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tick generator
// movement and bullet step enables on CLK
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tick_gen
#(
	parameter int MOVE_DIV = 5000000,
	parameter int STEP_DIV = 1000000
)
(
	input  logic CLK,
	input  logic Clear,
	output logic move_tick,
	output logic step_tick
);

	logic [1:0] ticks;

	// one wrapping counter per divider
	for (genvar i = 0; i < 2; i++)
	begin : g_div
		localparam int DIV = (i == 0) ? MOVE_DIV : STEP_DIV;
		localparam int CW  = $clog2(DIV + 1);

		logic [CW-1:0] cnt;

		always_ff @(posedge CLK or posedge Clear)
		begin
			if (Clear)
				cnt <= '0;
			else if (cnt == CW'(DIV - 1))
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end

		assign ticks[i] = (cnt == CW'(DIV - 1)); // last count of the period
	end

	assign move_tick = ticks[0];
	assign step_tick = ticks[1];

endmodule

`default_nettype wire

//--- rtl/player_ctrl.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// player position
// one step per move tick, clamped at the edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module player_ctrl
	import duel_pkg::*;
#(
	parameter row_t START_ROW = A_START_ROW
)
(
	input  logic        CLK,
	input  logic        Clear,
	input  logic        move_tick,
	input  logic        up,
	input  logic        down,
	input  logic        left,
	input  logic        right,
	input  game_state_t state,
	output row_t        row,
	output col_t        col
);

	logic can_move;

	assign can_move = move_tick && (state == ST_PLAY); // frozen after game over

	// up wins over down
	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			row <= START_ROW;
		else if (can_move)
		begin
			if (up)
			begin
				if (row != '0)
					row <= row - 1'b1;
			end
			else if (down)
			begin
				if (row != row_t'(GRID - 1))
					row <= row + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			col <= START_COL;
		else if (can_move)
		begin
			if (left)
			begin
				if (col != '0)
					col <= col - 1'b1;
			end
			else if (right)
			begin
				if (col != col_t'(GRID - 1))
					col <= col + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/volley_unit.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// volley unit
// ammo count, firing and bullet travel for one player
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module volley_unit
	import duel_pkg::*;
(
	input  logic        CLK,
	input  logic        Clear,
	input  logic        step_tick,
	input  logic        attack,
	input  row_t        row,
	input  col_t        col,
	input  game_state_t state,
	volley_if.source    vol,
	output ammo_t       ammo
);

	logic up_live;
	logic down_live;
	row_t up_row;
	row_t down_row;
	col_t vol_col;
	logic fire;
	logic up_at_edge;
	logic down_at_edge;

	// new volley only once both bullets of the last one are gone
	assign fire = step_tick && attack && !up_live && !down_live
		&& (ammo != '0) && (state == ST_PLAY);

	assign up_at_edge   = (up_row == '0);
	assign down_at_edge = (down_row == row_t'(GRID - 1));

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			ammo <= AMMO_FULL;
		else if (fire)
			ammo <= ammo - 1'b1;
	end

	// live flags, kill from the judge has priority over stepping
	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			up_live   <= 1'b0;
			down_live <= 1'b0;
		end
		else if (fire)
		begin
			up_live   <= 1'b1;
			down_live <= 1'b1;
		end
		else
		begin
			if (vol.kill_up || (step_tick && up_at_edge))
				up_live <= 1'b0;
			if (vol.kill_down || (step_tick && down_at_edge))
				down_live <= 1'b0;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (fire)
		begin
			up_row   <= row; // both start on the shooter
			down_row <= row;
			vol_col  <= col;
		end
		else if (step_tick)
		begin
			if (up_live && !up_at_edge)
				up_row <= up_row - 1'b1;
			if (down_live && !down_at_edge)
				down_row <= down_row + 1'b1;
		end
	end

	assign vol.up_live   = up_live;
	assign vol.up_row    = up_row;
	assign vol.down_live = down_live;
	assign vol.down_row  = down_row;
	assign vol.col       = vol_col;

endmodule

`default_nettype wire

//--- rtl/hit_judge.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hit judge
// bullet matching, lives, hit pulse, game result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module hit_judge
	import duel_pkg::*;
(
	input  logic        CLK,
	input  logic        Clear,
	volley_if.judge     a_vol,
	volley_if.judge     b_vol,
	input  row_t        a_row,
	input  row_t        b_row,
	input  col_t        a_col,
	input  col_t        b_col,
	input  logic        a_defense,
	input  logic        b_defense,
	output life_t       a_life,
	output life_t       b_life,
	output game_state_t state,
	output logic        hit
);

	logic a_up_on_b;
	logic a_down_on_b;
	logic b_up_on_a;
	logic b_down_on_a;
	logic in_play;
	logic a_damaged;
	logic b_damaged;

	// A's bullets against B's cell and the other way round
	assign a_up_on_b   = a_vol.up_live && (a_vol.up_row == b_row) && (a_vol.col == b_col);
	assign a_down_on_b = a_vol.down_live && (a_vol.down_row == b_row) && (a_vol.col == b_col);
	assign b_up_on_a   = b_vol.up_live && (b_vol.up_row == a_row) && (b_vol.col == a_col);
	assign b_down_on_a = b_vol.down_live && (b_vol.down_row == a_row) && (b_vol.col == a_col);

	assign a_vol.kill_up   = a_up_on_b; // absorbed even when defended
	assign a_vol.kill_down = a_down_on_b;
	assign b_vol.kill_up   = b_up_on_a;
	assign b_vol.kill_down = b_down_on_a;

	assign in_play   = (state == ST_PLAY) && (a_life != '0) && (b_life != '0);
	assign b_damaged = in_play && (a_up_on_b || a_down_on_b) && !b_defense;
	assign a_damaged = in_play && (b_up_on_a || b_down_on_a) && !a_defense;

	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
		begin
			a_life <= LIFE_FULL;
			b_life <= LIFE_FULL;
			hit    <= 1'b0;
		end
		else
		begin
			hit <= a_damaged || b_damaged;
			if (a_damaged)
				a_life <= a_life >> 1; // halve per hit
			if (b_damaged)
				b_life <= b_life >> 1;
		end
	end

	// result is latched until Clear
	always_ff @(posedge CLK or posedge Clear)
	begin
		if (Clear)
			state <= ST_PLAY;
		else if (state == ST_PLAY)
		begin
			if (a_life == '0 && b_life == '0)
				state <= ST_DRAW;
			else if (b_life == '0)
				state <= ST_A_WINS;
			else if (a_life == '0)
				state <= ST_B_WINS;
		end
	end

endmodule

`default_nettype wire

//--- rtl/duel_top.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// duel top level
// two players, two volley units, ticks and judge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module duel_top
	import duel_pkg::*;
#(
	parameter int MOVE_DIV = 5000000,
	parameter int STEP_DIV = 1000000
)
(
	input  logic        CLK,
	input  logic        Clear,
	input  logic        a_up,
	input  logic        a_down,
	input  logic        a_left,
	input  logic        a_right,
	input  logic        a_attack,
	input  logic        a_defense,
	input  logic        b_up,
	input  logic        b_down,
	input  logic        b_left,
	input  logic        b_right,
	input  logic        b_attack,
	input  logic        b_defense,
	output row_t        a_row,
	output row_t        b_row,
	output col_t        a_col,
	output col_t        b_col,
	output life_t       a_life,
	output life_t       b_life,
	output ammo_t       a_ammo,
	output ammo_t       b_ammo,
	output game_state_t state,
	output logic        hit
);

	logic move_tick;
	logic step_tick;

	volley_if a_vol_if ();
	volley_if b_vol_if ();

	tick_gen #(
		.MOVE_DIV(MOVE_DIV),
		.STEP_DIV(STEP_DIV)
	) tick_gen_inst (
		.CLK(CLK), .Clear(Clear), .move_tick(move_tick), .step_tick(step_tick)
	);

	player_ctrl #(.START_ROW(A_START_ROW)) a_player_inst (
		.CLK(CLK), .Clear(Clear), .move_tick(move_tick),
		.up(a_up), .down(a_down), .left(a_left), .right(a_right),
		.state(state), .row(a_row), .col(a_col)
	);

	player_ctrl #(.START_ROW(B_START_ROW)) b_player_inst (
		.CLK(CLK), .Clear(Clear), .move_tick(move_tick),
		.up(b_up), .down(b_down), .left(b_left), .right(b_right),
		.state(state), .row(b_row), .col(b_col)
	);

	volley_unit a_volley_inst (
		.CLK(CLK), .Clear(Clear), .step_tick(step_tick), .attack(a_attack),
		.row(a_row), .col(a_col), .state(state), .vol(a_vol_if.source), .ammo(a_ammo)
	);

	volley_unit b_volley_inst (
		.CLK(CLK), .Clear(Clear), .step_tick(step_tick), .attack(b_attack),
		.row(b_row), .col(b_col), .state(state), .vol(b_vol_if.source), .ammo(b_ammo)
	);

	hit_judge hit_judge_inst (
		.CLK(CLK), .Clear(Clear),
		.a_vol(a_vol_if.judge), .b_vol(b_vol_if.judge),
		.a_row(a_row), .b_row(b_row), .a_col(a_col), .b_col(b_col),
		.a_defense(a_defense), .b_defense(b_defense),
		.a_life(a_life), .b_life(b_life), .state(state), .hit(hit)
	);

endmodule

`default_nettype wire

//--- sim/duel_assert.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// duel properties
// lives, ammo, frozen positions, hit pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module duel_assert
	import duel_pkg::*;
(
	input logic        CLK,
	input logic        Clear,
	input row_t        a_row,
	input row_t        b_row,
	input col_t        a_col,
	input col_t        b_col,
	input life_t       a_life,
	input life_t       b_life,
	input ammo_t       a_ammo,
	input ammo_t       b_ammo,
	input game_state_t state,
	input logic        hit
);

	a_life_no_gain: assert property (@(posedge CLK) disable iff (Clear) a_life <= $past(a_life))
		else $error("a_life increased outside Clear");
	b_life_no_gain: assert property (@(posedge CLK) disable iff (Clear) b_life <= $past(b_life))
		else $error("b_life increased outside Clear");
	a_ammo_no_gain: assert property (@(posedge CLK) disable iff (Clear) a_ammo <= $past(a_ammo))
		else $error("a_ammo increased outside Clear");
	b_ammo_no_gain: assert property (@(posedge CLK) disable iff (Clear) b_ammo <= $past(b_ammo))
		else $error("b_ammo increased outside Clear");

	// board is frozen once a result is latched
	pos_frozen: assert property (@(posedge CLK) disable iff (Clear)
		(state != ST_PLAY) |=> $stable({a_row, a_col, b_row, b_col}))
		else $error("player moved after the game ended");

	hit_single: assert property (@(posedge CLK) disable iff (Clear) hit |=> !hit)
		else $error("hit stayed high for two cycles");

endmodule

bind duel_top duel_assert duel_assert_inst (
	.CLK(CLK), .Clear(Clear), .a_row(a_row), .b_row(b_row), .a_col(a_col), .b_col(b_col),
	.a_life(a_life), .b_life(b_life), .a_ammo(a_ammo), .b_ammo(b_ammo),
	.state(state), .hit(hit)
);

`default_nettype wire

//--- sim/duel_tb.sv
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// duel testbench
// replays button holds from a file and checks outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module duel_tb
	import duel_pkg::*;
();

	localparam int DEPTH = 64;

	logic        CLK;
	logic        Clear;
	logic [11:0] buttons; // A up down left right attack defense, then B
	row_t        a_row;
	row_t        b_row;
	col_t        a_col;
	col_t        b_col;
	life_t       a_life;
	life_t       b_life;
	ammo_t       a_ammo;
	ammo_t       b_ammo;
	game_state_t state;
	logic        hit;
	logic [43:0] recs [DEPTH];
	int          errors;
	int          hit_count;
	int          hold_total;
	logic        limit_ready;

	duel_top #(.MOVE_DIV(4), .STEP_DIV(2)) duel_top_inst (
		.CLK(CLK), .Clear(Clear),
		.a_up(buttons[11]), .a_down(buttons[10]), .a_left(buttons[9]), .a_right(buttons[8]),
		.a_attack(buttons[7]), .a_defense(buttons[6]),
		.b_up(buttons[5]), .b_down(buttons[4]), .b_left(buttons[3]), .b_right(buttons[2]),
		.b_attack(buttons[1]), .b_defense(buttons[0]),
		.a_row(a_row), .b_row(b_row), .a_col(a_col), .b_col(b_col),
		.a_life(a_life), .b_life(b_life), .a_ammo(a_ammo), .b_ammo(b_ammo),
		.state(state), .hit(hit)
	);

	always #5 CLK = ~CLK;

	always @(negedge CLK) // away from the updating edge
	begin
		if (!Clear && hit)
			hit_count++;
	end

	task automatic compare_value(input string test, input string field, input int expected,
		input int actual);
		if (actual != expected)
		begin
			$display("FAILED %s %s: expected %0d, actual %0d", test, field, expected, actual);
			errors++;
		end
	endtask

	task automatic hold_buttons(input logic [11:0] mask, input int cycles);
		buttons = mask;
		repeat (cycles)
		begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic check_outputs(input logic [43:0] rec, input int num);
		string test;
		test = $sformatf("check %0d", num);
		compare_value(test, "a_row", int'(rec[39:36]), int'(a_row));
		compare_value(test, "a_col", int'(rec[35:32]), int'(a_col));
		compare_value(test, "b_row", int'(rec[31:28]), int'(b_row));
		compare_value(test, "b_col", int'(rec[27:24]), int'(b_col));
		compare_value(test, "a_life", int'(rec[23:20]), int'(a_life));
		compare_value(test, "b_life", int'(rec[19:16]), int'(b_life));
		compare_value(test, "a_ammo", int'(rec[15:12]), int'(a_ammo));
		compare_value(test, "b_ammo", int'(rec[11:8]), int'(b_ammo));
		compare_value(test, "state", int'(rec[7:4]), int'(state));
		compare_value(test, "hits", int'(rec[3:0]), hit_count);
	endtask

	initial
	begin
		int idx;
		int checks;
		CLK = 1'b0;
		Clear = 1'b1;
		buttons = '0;
		errors = 0;
		hit_count = 0;
		hold_total = 0;
		checks = 0;
		for (idx = 0; idx < DEPTH; idx++)
			recs[idx] = '0;
		$readmemh("sim/duel_input.txt", recs);
		for (idx = 0; idx < DEPTH; idx++)
		begin
			if (recs[idx][43:40] == 4'h1)
				hold_total += int'(recs[idx][27:12]);
		end
		limit_ready = 1'b1;

		repeat (16) @(posedge CLK);
		#1;
		Clear = 1'b0;

		idx = 0;
		while (idx < DEPTH && recs[idx][43:40] != 4'h0)
		begin
			if (recs[idx][43:40] == 4'h1)
				hold_buttons(recs[idx][39:28], int'(recs[idx][27:12]));
			else if (recs[idx][43:40] == 4'h2)
			begin
				checks++;
				check_outputs(recs[idx], checks);
			end
			else
			begin
				$display("record %0d in the input file has an unknown kind", idx);
				errors++;
			end
			idx++;
		end
		if (checks == 0)
		begin
			$display("no check records were read from the input file");
			errors++;
		end

		$display("errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// limit from reset plus all hold cycles
	initial
	begin
		wait (limit_ready === 1'b1);
		#((16 + hold_total) * 10 + 500);
		$display("timeout: the record replay did not finish in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: duel

sources:
  - rtl/duel_pkg.sv
  - rtl/volley_if.sv
  - rtl/tick_gen.sv
  - rtl/player_ctrl.sv
  - rtl/volley_unit.sv
  - rtl/hit_judge.sv
  - rtl/duel_top.sv
  - target: simulation
    files:
      - sim/duel_assert.sv
      - sim/duel_tb.sv

//--- vlog.f
rtl/duel_pkg.sv
rtl/volley_if.sv
rtl/tick_gen.sv
rtl/player_ctrl.sv
rtl/volley_unit.sv
rtl/hit_judge.sv
rtl/duel_top.sv
sim/duel_assert.sv
sim/duel_tb.sv

//--- sim/duel_input.txt
// hold : 1_mmm_cccc_000   mmm buttons (A up down left right attack defense, then B), cccc cycles
// check: 2_rcrc_llaa_s_h  A row col, B row col, lives A B, ammo A B, state, hit count
2_7404_FF99_0_0 // after reset
1_A04_0028_000  // A up and left, B right
2_0007_FF99_0_0
1_080_0002_000  // single A volley, columns apart
1_000_001E_000
2_0007_FF89_0_0
1_002_00C8_000  // B fires until empty and keeps pressing
2_0007_FF80_0_0
1_408_0028_000  // A down, B left into column 0
2_7000_FF80_0_0
1_081_0002_000  // A volley while B defends
1_001_001E_000
2_7000_FF70_0_0
1_080_0002_000  // undefended A volleys
1_000_001E_000
2_7000_F760_0_1
1_080_0002_000
1_000_001E_000
2_7000_F350_0_2
1_080_0002_000
1_000_001E_000
2_7000_F140_0_3
1_080_0002_000
1_000_001E_000
2_7000_F030_1_4
1_996_0028_000  // moves and shots after game over
2_7000_F030_1_4
0_000_0000_000  // end
